// ==== design/arcade_input_pkg.sv ====
// Shared types and constants for the arcade input subsystem, imported by its RTL modules
package arcade_input_pkg;

	// ==============================
	// Game codes and download indices
	// ==============================

	typedef enum logic [7:0] {
		SHOLLOW  = 8'd0,
		TRON     = 8'd1,
		TWOTIGER = 8'd2,
		WACKO    = 8'd3,
		KROOZR   = 8'd4,
		DOMINO   = 8'd5
	} game_t;

	localparam logic [7:0] IDX_ROM  = 8'd0;
	localparam logic [7:0] IDX_GAME = 8'd1;
	localparam logic [7:0] IDX_DIP  = 8'd254;

	// One beat of the download stream
	typedef struct packed {
		logic        download;
		logic        wr;
		logic [7:0]  index;
		logic [23:0] addr;
		logic [7:0]  data;
	} dl_write_t;

	// ==============================
	// Player and port bundles
	// ==============================

	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
		logic fire_a;
		logic fire_b;
		logic fire_c;
		logic fire_d;
		logic rcw;
		logic rccw;
		logic spccw;
		logic spcw;
	} player_ctrl_t;

	typedef struct packed {
		logic start1;
		logic start2;
		logic coin;
	} sys_ctrl_t;

	// All five bytes are active low towards the game board
	typedef struct packed {
		logic [7:0] in0;
		logic [7:0] in1;
		logic [7:0] in2;
		logic [7:0] in3;
		logic [7:0] in4;
	} input_ports_t;

	// Analog stick emulation for Krooz'r
	localparam logic [7:0] KROOZR_CENTER = 8'd100;
	localparam logic [7:0] KROOZR_SWING  = 8'd63;

endpackage

// ==== design/download_regs.sv ====
// Captures game select and DIP bytes from the download stream and generates the core reset
`timescale 1ns/1ps

module download_regs import arcade_input_pkg::*; #(
	parameter int RESET_HOLD = 40000000
) (
	input  logic       clk_sys,
	input  logic       rst,
	input  dl_write_t  dl,
	input  logic       status_reset,
	output game_t      game,
	output logic [7:0] dip_bank0,
	output logic       service,
	output logic       core_reset,
	output logic       led_user
);

	localparam int CNT_W = $clog2(RESET_HOLD + 1);

	logic [7:0]       game_code;
	logic [7:0]       dip [8];
	logic             rom_download;
	logic             rom_download_d;
	logic             rom_loaded;
	logic [CNT_W-1:0] hold_cnt;

	assign rom_download = dl.download && (dl.index == IDX_ROM);
	assign led_user     = rom_download;
	assign dip_bank0    = dip[0];
	assign service      = dip[1][0];

	// Game code is staged once more before it reaches the mux
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			game_code <= '0;
			game      <= SHOLLOW;
		end else begin
			if (dl.wr && (dl.index == IDX_GAME)) begin
				game_code <= dl.data;
			end
			game <= game_t'(game_code);
		end
	end

	// Only the first eight DIP addresses are kept
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			for (int i = 0; i < 8; i++) begin
				dip[i] <= '0;
			end
		end else if (dl.wr && (dl.index == IDX_DIP) && (dl.addr[23:3] == '0)) begin
			dip[dl.addr[2:0]] <= dl.data;
		end
	end

	// ==============================
	// Core reset
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			rom_download_d <= 1'b0;
			rom_loaded     <= 1'b0;
			hold_cnt       <= '0;
			core_reset     <= 1'b1;
		end else begin
			rom_download_d <= rom_download;
			if (hold_cnt != '0) begin
				hold_cnt <= hold_cnt - CNT_W'(1);
			end
			// End of the ROM download marks the image as loaded
			if (rom_download_d && !rom_download) begin
				rom_loaded <= 1'b1;
			end
			// Counter sits at full hold until the load completes
			if (!rom_loaded) begin
				hold_cnt <= CNT_W'(RESET_HOLD);
			end
			core_reset <= status_reset | rom_download | ~rom_loaded |
				(hold_cnt == CNT_W'(1));
		end
	end

endmodule

// ==== design/ps2_key_decoder.sv ====
// Decodes keyboard scan events into held button states for two players and the system keys
`timescale 1ns/1ps

module ps2_key_decoder import arcade_input_pkg::*; (
	input  logic         clk_sys,
	input  logic         rst,
	input  logic [10:0]  ps2_key,
	output player_ctrl_t kb_p1,
	output player_ctrl_t kb_p2,
	output sys_ctrl_t    kb_sys
);

	// Registered event: toggle, pressed, scan code
	logic [9:0] key_q;
	logic       toggle_q;
	logic       pressed;
	logic [7:0] code;

	assign pressed = key_q[8];
	assign code    = key_q[7:0];

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			// Track the current toggle so no event fires on release of reset
			key_q    <= {ps2_key[10:9], ps2_key[7:0]};
			toggle_q <= ps2_key[10];
			kb_p1    <= '0;
			kb_p2    <= '0;
			kb_sys   <= '0;
		end else begin
			key_q    <= {ps2_key[10:9], ps2_key[7:0]};
			toggle_q <= key_q[9];
			if (key_q[9] != toggle_q) begin
				case (code)
					// Player 1 arrows and fire keys
					8'h75: kb_p1.up     <= pressed;
					8'h72: kb_p1.down   <= pressed;
					8'h6B: kb_p1.left   <= pressed;
					8'h74: kb_p1.right  <= pressed;
					8'h14: kb_p1.fire_a <= pressed;
					8'h11: kb_p1.fire_b <= pressed;
					8'h29: kb_p1.fire_c <= pressed;
					8'h12: kb_p1.fire_d <= pressed;
					// Player 2 on the left hand letter block
					8'h2D: kb_p2.up     <= pressed;
					8'h2B: kb_p2.down   <= pressed;
					8'h23: kb_p2.left   <= pressed;
					8'h34: kb_p2.right  <= pressed;
					8'h1C: kb_p2.fire_a <= pressed;
					8'h1B: kb_p2.fire_b <= pressed;
					8'h21: kb_p2.fire_c <= pressed;
					8'h1D: kb_p2.fire_d <= pressed;
					// Function keys plus the MAME style number row
					8'h05, 8'h16: kb_sys.start1 <= pressed;
					8'h06, 8'h1E: kb_sys.start2 <= pressed;
					8'h76, 8'h2E, 8'h36: kb_sys.coin <= pressed;
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== design/spinner.sv ====
// Position counter for an emulated spinner, stepped once per rising edge of the sync strobe
`timescale 1ns/1ps

module spinner #(
	parameter int STEP = 10
) (
	input  logic       clk_sys,
	input  logic       rst,
	input  logic       minus,
	input  logic       plus,
	input  logic       strobe,
	output logic [7:0] position
);

	logic strobe_q;
	logic strobe_qq;
	logic strobe_rise;

	assign strobe_rise = strobe_q & ~strobe_qq;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			strobe_q  <= 1'b0;
			strobe_qq <= 1'b0;
			position  <= '0;
		end else begin
			strobe_q  <= strobe;
			strobe_qq <= strobe_q;
			// Both directions held cancel out
			if (strobe_rise) begin
				if (plus && !minus) begin
					position <= position + 8'(STEP);
				end else if (minus && !plus) begin
					position <= position - 8'(STEP);
				end
			end
		end
	end

endmodule

// ==== design/input_port_mux.sv ====
// Merges keyboard and joystick controls and packs the per-game input ports and orientation
`timescale 1ns/1ps

module input_port_mux import arcade_input_pkg::*; (
	input  game_t        game,
	input  logic [7:0]   dip_bank0,
	input  logic         service,
	input  player_ctrl_t kb_p1,
	input  player_ctrl_t kb_p2,
	input  sys_ctrl_t    kb_sys,
	input  logic [31:0]  joy1,
	input  logic [31:0]  joy2,
	input  logic [7:0]   spin_tron,
	input  logic [7:0]   spin_tiger1,
	input  logic [7:0]   spin_tiger2,
	input  logic [7:0]   spin_wx,
	input  logic [7:0]   spin_wy,
	output player_ctrl_t p1,
	output player_ctrl_t p2,
	output player_ctrl_t any_player,
	output input_ports_t ports,
	output logic [1:0]   orientation
);

	localparam logic TILT = 1'b0;

	logic start1;
	logic start2;
	logic coin;
	logic x_bit;
	logic game_known;

	// Keyboard OR joystick for one player
	function automatic player_ctrl_t merge(player_ctrl_t kb, logic [31:0] joy);
		player_ctrl_t m;
		m.right  = kb.right  | joy[0];
		m.left   = kb.left   | joy[1];
		m.down   = kb.down   | joy[2];
		m.up     = kb.up     | joy[3];
		m.fire_a = kb.fire_a | joy[4];
		m.fire_b = kb.fire_b | joy[5];
		m.fire_c = kb.fire_c | joy[6];
		m.fire_d = kb.fire_d | joy[7];
		m.rcw    = kb.rcw    | joy[8];
		m.rccw   = kb.rccw   | joy[9];
		m.spccw  = kb.spccw  | joy[30];
		m.spcw   = kb.spcw   | joy[31];
		return m;
	endfunction

	assign p1         = merge(kb_p1, joy1);
	assign p2         = merge(kb_p2, joy2);
	assign any_player = p1 | p2;
	assign start1     = kb_sys.start1 | joy1[10] | joy2[10];
	assign start2     = kb_sys.start2 | joy1[11] | joy2[11];
	assign coin       = kb_sys.coin   | joy1[12] | joy2[12];

	// ==============================
	// Per-game port packing
	// ==============================

	always_comb begin
		ports       = {8'hff, 8'hff, 8'hff, dip_bank0, 8'hff};
		orientation = 2'b01;
		x_bit       = any_player.fire_a;
		game_known  = 1'b1;
		case (game)
			SHOLLOW: begin
				orientation = 2'b00;
				x_bit       = 1'b0;
				ports.in1   = ~{2{any_player.fire_a, any_player.fire_b,
					any_player.right, any_player.left}};
			end
			TRON: begin
				orientation  = 2'b00;
				ports.in1    = ~{1'b0, spin_tron[7:1]};
				ports.in2    = ~{2{any_player.down, any_player.up,
					any_player.right, any_player.left}};
				ports.in3[7] = ~any_player.fire_a;
				ports.in4    = ~{1'b0, spin_tron[7:1]};
			end
			TWOTIGER: begin
				x_bit     = any_player.fire_c;
				ports.in1 = ~{1'b0, spin_tiger1[7:1]};
				ports.in2 = ~{4'b0000, p2.fire_b, p2.fire_a, p1.fire_b, p1.fire_a};
				ports.in4 = ~{1'b0, spin_tiger2[7:1]};
			end
			WACKO: begin
				x_bit     = 1'b0;
				ports.in1 = spin_wx;
				ports.in2 = spin_wy;
				ports.in4 = ~{2{any_player.fire_c, any_player.fire_b,
					any_player.fire_d, any_player.fire_a}};
			end
			KROOZR: begin
				ports.in1 = ~{any_player.fire_b, spin_tron[7], 3'b111, spin_tron[6:4]};
				// Digital stick mapped onto the analog range
				ports.in2 = any_player.left  ? KROOZR_CENTER - KROOZR_SWING :
					any_player.right ? KROOZR_CENTER + KROOZR_SWING : KROOZR_CENTER;
				ports.in4 = any_player.up    ? KROOZR_CENTER - KROOZR_SWING :
					any_player.down  ? KROOZR_CENTER + KROOZR_SWING : KROOZR_CENTER;
			end
			DOMINO: begin
				ports.in1 = ~{4'b0000, any_player.down, any_player.up,
					any_player.right, any_player.left};
				ports.in2 = ~{3'b000, any_player.fire_a, any_player.down, any_player.up,
					any_player.right, any_player.left};
			end
			default: begin
				orientation = 2'b00;
				game_known  = 1'b0;
			end
		endcase
		// Coin and start layout shared by all six boards
		if (game_known) begin
			ports.in0 = ~{service, 1'b0, TILT, x_bit, start2, start1, 1'b0, coin};
		end
	end

endmodule

// ==== design/arcade_input_top.sv ====
// Top level of the arcade input subsystem, joining download, keyboard, spinners and port mux
`timescale 1ns/1ps

module arcade_input_top import arcade_input_pkg::*; #(
	parameter int RESET_HOLD = 40000000
) (
	input  logic         clk_sys,
	input  logic         rst,
	input  dl_write_t    dl,
	input  logic         status_reset,
	input  logic [10:0]  ps2_key,
	input  logic [31:0]  joy1,
	input  logic [31:0]  joy2,
	input  logic         vsync,
	output input_ports_t ports,
	output logic [1:0]   orientation,
	output logic         core_reset,
	output logic         led_user
);

	game_t        game;
	logic [7:0]   dip_bank0;
	logic         service;
	player_ctrl_t kb_p1;
	player_ctrl_t kb_p2;
	sys_ctrl_t    kb_sys;
	player_ctrl_t p1;
	player_ctrl_t p2;
	player_ctrl_t any_player;
	logic [7:0]   spin_tron;
	logic [7:0]   spin_tiger1;
	logic [7:0]   spin_tiger2;
	logic [7:0]   spin_wx;
	logic [7:0]   spin_wy;

	download_regs #(.RESET_HOLD(RESET_HOLD)) u_download_regs (
		.clk_sys, .rst, .dl, .status_reset, .game, .dip_bank0, .service,
		.core_reset, .led_user
	);

	ps2_key_decoder u_ps2_key_decoder (.clk_sys, .rst, .ps2_key, .kb_p1, .kb_p2, .kb_sys);

	input_port_mux u_input_port_mux (
		.game, .dip_bank0, .service, .kb_p1, .kb_p2, .kb_sys, .joy1, .joy2,
		.spin_tron, .spin_tiger1, .spin_tiger2, .spin_wx, .spin_wy,
		.p1, .p2, .any_player, .ports, .orientation
	);

	// ==============================
	// Spinners, one per controlled axis
	// ==============================

	// Shared by Tron and Krooz'r
	spinner #(.STEP(12)) spinner_tron (.clk_sys, .rst(core_reset),
		.minus(any_player.rccw | any_player.spccw),
		.plus(any_player.rcw | any_player.spcw), .strobe(vsync), .position(spin_tron));

	spinner #(.STEP(25)) spinner_tiger1 (.clk_sys, .rst(core_reset),
		.minus(p1.rccw | p1.left | p1.spccw),
		.plus(p1.rcw | p1.right | p1.spcw), .strobe(vsync), .position(spin_tiger1));

	spinner #(.STEP(25)) spinner_tiger2 (.clk_sys, .rst(core_reset),
		.minus(p2.rccw | p2.left | p2.spccw),
		.plus(p2.rcw | p2.right | p2.spcw), .strobe(vsync), .position(spin_tiger2));

	// Wacko crosshair axes
	spinner #(.STEP(10)) spinner_wx (.clk_sys, .rst(core_reset), .minus(any_player.left),
		.plus(any_player.right), .strobe(vsync), .position(spin_wx));

	spinner #(.STEP(10)) spinner_wy (.clk_sys, .rst(core_reset), .minus(any_player.down),
		.plus(any_player.up), .strobe(vsync), .position(spin_wy));

endmodule

// ==== tests/arcade_input_asserts.sv ====
// Concurrent checks on the core reset of download_regs, attached by the bind at the bottom
`timescale 1ns/1ps

module arcade_input_asserts import arcade_input_pkg::*; (
	input logic      clk_sys,
	input logic      rst,
	input dl_write_t dl,
	input logic      core_reset
);

	// Core held in reset for the whole ROM download
	rom_download_holds_reset: assert property (@(posedge clk_sys)
		(dl.download && dl.index == IDX_ROM) |=> core_reset)
		else $error("core_reset low during a ROM download");

	reset_follows_rst: assert property (@(posedge clk_sys) rst |=> core_reset)
		else $error("core_reset low in the cycle after rst");

endmodule

bind download_regs arcade_input_asserts u_asserts (
	.clk_sys(clk_sys), .rst(rst), .dl(dl), .core_reset(core_reset)
);

// ==== tests/input_checker.sv ====
// Watches the DUT, keeps a behavioral model of the input subsystem and compares its outputs
`timescale 1ns/1ps

module input_checker import arcade_input_pkg::*; #(
	parameter int RESET_HOLD = 16
) (
	input  logic         clk_sys,
	input  logic         rst,
	input  dl_write_t    dl,
	input  logic         status_reset,
	input  logic [10:0]  ps2_key,
	input  logic [31:0]  joy1,
	input  logic [31:0]  joy2,
	input  logic         vsync,
	input  input_ports_t ports,
	input  logic [1:0]   orientation,
	input  logic         core_reset,
	input  logic         led_user,
	input  logic         check_now,
	input  int           test_id,
	input  logic         test_done,
	input  logic         all_done,
	output int           error_count
);

	// Button bit positions in the model vectors
	localparam int B_RIGHT = 0;
	localparam int B_LEFT  = 1;
	localparam int B_DOWN  = 2;
	localparam int B_UP    = 3;
	localparam int B_FA    = 4;
	localparam int B_FB    = 5;
	localparam int B_FC    = 6;
	localparam int B_FD    = 7;
	localparam int B_RCW   = 8;
	localparam int B_RCCW  = 9;
	localparam int B_SPCCW = 10;
	localparam int B_SPCW  = 11;

	string test_names [5] = '{"rom_load_reset", "dip_and_game_select", "random_joysticks",
		"keyboard_events", "spinners"};

	logic [7:0]  game_m;
	logic [7:0]  dip_m [8];
	logic [11:0] kb1_m;
	logic [11:0] kb2_m;
	logic [2:0]  sys_m;
	logic        last_tog;
	logic        dl_prev;
	logic        vs_prev;
	logic        loaded;
	logic        cr_exp;
	logic        started = 1'b0;
	int          n_after;
	logic [7:0]  sp_tron;
	logic [7:0]  sp_t1;
	logic [7:0]  sp_t2;
	logic [7:0]  sp_wx;
	logic [7:0]  sp_wy;
	int          test_checks = 0;
	int          test_errors = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;

	initial error_count = 0;

	function automatic logic [11:0] merged(input logic [11:0] kb, input logic [31:0] joy);
		return kb | {joy[31], joy[30], joy[9:0]};
	endfunction

	function automatic logic [7:0] spin_step(input logic [7:0] pos, input logic minus,
		input logic plus, input int step);
		if (plus && !minus) begin
			return pos + 8'(step);
		end
		if (minus && !plus) begin
			return pos - 8'(step);
		end
		return pos;
	endfunction

	task automatic apply_key(input logic [7:0] code, input logic pressed);
		case (code)
			8'h75: kb1_m[B_UP] = pressed;
			8'h72: kb1_m[B_DOWN] = pressed;
			8'h6B: kb1_m[B_LEFT] = pressed;
			8'h74: kb1_m[B_RIGHT] = pressed;
			8'h14: kb1_m[B_FA] = pressed;
			8'h11: kb1_m[B_FB] = pressed;
			8'h29: kb1_m[B_FC] = pressed;
			8'h12: kb1_m[B_FD] = pressed;
			8'h2D: kb2_m[B_UP] = pressed;
			8'h2B: kb2_m[B_DOWN] = pressed;
			8'h23: kb2_m[B_LEFT] = pressed;
			8'h34: kb2_m[B_RIGHT] = pressed;
			8'h1C: kb2_m[B_FA] = pressed;
			8'h1B: kb2_m[B_FB] = pressed;
			8'h21: kb2_m[B_FC] = pressed;
			8'h1D: kb2_m[B_FD] = pressed;
			8'h05, 8'h16: sys_m[0] = pressed;
			8'h06, 8'h1E: sys_m[1] = pressed;
			8'h76, 8'h2E, 8'h36: sys_m[2] = pressed;
			default: ;
		endcase
	endtask

	// ==============================
	// Reference for ports and orientation
	// ==============================

	function automatic logic [41:0] reference_ports();
		logic [11:0] q1;
		logic [11:0] q2;
		logic [11:0] a;
		logic [2:0]  s;
		logic [7:0]  i0;
		logic [7:0]  i1;
		logic [7:0]  i2;
		logic [7:0]  i3;
		logic [7:0]  i4;
		logic        x;
		q1 = merged(kb1_m, joy1);
		q2 = merged(kb2_m, joy2);
		a  = q1 | q2;
		s  = sys_m | {joy1[12] | joy2[12], joy1[11] | joy2[11], joy1[10] | joy2[10]};
		i1 = 8'hff;
		i2 = 8'hff;
		i3 = dip_m[0];
		i4 = 8'hff;
		x  = 1'b0;
		case (game_m)
			8'd0: i1 = ~{a[B_FA], a[B_FB], a[B_RIGHT], a[B_LEFT],
				a[B_FA], a[B_FB], a[B_RIGHT], a[B_LEFT]};
			8'd1: begin
				x     = a[B_FA];
				i1    = ~{1'b0, sp_tron[7:1]};
				i4    = i1;
				i2    = ~{a[B_DOWN], a[B_UP], a[B_RIGHT], a[B_LEFT],
					a[B_DOWN], a[B_UP], a[B_RIGHT], a[B_LEFT]};
				i3[7] = ~a[B_FA];
			end
			8'd2: begin
				x  = a[B_FC];
				i1 = ~{1'b0, sp_t1[7:1]};
				i4 = ~{1'b0, sp_t2[7:1]};
				i2 = ~{4'h0, q2[B_FB], q2[B_FA], q1[B_FB], q1[B_FA]};
			end
			8'd3: begin
				i1 = sp_wx;
				i2 = sp_wy;
				i4 = ~{a[B_FC], a[B_FB], a[B_FD], a[B_FA], a[B_FC], a[B_FB], a[B_FD], a[B_FA]};
			end
			8'd4: begin
				x  = a[B_FA];
				i1 = ~{a[B_FB], sp_tron[7], 3'b111, sp_tron[6:4]};
				i2 = a[B_LEFT] ? 8'd37 : (a[B_RIGHT] ? 8'd163 : 8'd100);
				i4 = a[B_UP] ? 8'd37 : (a[B_DOWN] ? 8'd163 : 8'd100);
			end
			default: begin
				x  = a[B_FA];
				i1 = ~{4'h0, a[B_DOWN], a[B_UP], a[B_RIGHT], a[B_LEFT]};
				i2 = ~{3'h0, a[B_FA], a[B_DOWN], a[B_UP], a[B_RIGHT], a[B_LEFT]};
			end
		endcase
		i0 = ~{dip_m[1][0], 1'b0, 1'b0, x, s[1], s[0], 1'b0, s[2]};
		return {i0, i1, i2, i3, i4, (game_m > 8'd1) ? 2'd1 : 2'd0};
	endfunction

	// ==============================
	// Model state, stepped like the DUT inputs are sampled
	// ==============================

	always @(posedge clk_sys) begin
		logic [11:0] q1;
		logic [11:0] q2;
		logic [11:0] a;
		logic        dlrom;
		q1      = merged(kb1_m, joy1);
		q2      = merged(kb2_m, joy2);
		a       = q1 | q2;
		dlrom   = dl.download && dl.index == IDX_ROM;
		started = 1'b1;
		// Spinners are cleared by the core reset
		if (cr_exp) begin
			{sp_tron, sp_t1, sp_t2, sp_wx, sp_wy} = '0;
			vs_prev = 1'b0;
		end else begin
			if (vsync && !vs_prev) begin
				sp_tron = spin_step(sp_tron, a[B_RCCW] | a[B_SPCCW], a[B_RCW] | a[B_SPCW], 12);
				sp_t1   = spin_step(sp_t1, q1[B_RCCW] | q1[B_LEFT] | q1[B_SPCCW],
					q1[B_RCW] | q1[B_RIGHT] | q1[B_SPCW], 25);
				sp_t2   = spin_step(sp_t2, q2[B_RCCW] | q2[B_LEFT] | q2[B_SPCCW],
					q2[B_RCW] | q2[B_RIGHT] | q2[B_SPCW], 25);
				sp_wx   = spin_step(sp_wx, a[B_LEFT], a[B_RIGHT], 10);
				sp_wy   = spin_step(sp_wy, a[B_DOWN], a[B_UP], 10);
			end
			vs_prev = vsync;
		end
		if (rst) begin
			game_m   = 8'd0;
			dip_m    = '{default: 8'h00};
			kb1_m    = '0;
			kb2_m    = '0;
			sys_m    = '0;
			last_tog = ps2_key[10];
			dl_prev  = 1'b0;
			loaded   = 1'b0;
			n_after  = 0;
			cr_exp   = 1'b1;
		end else begin
			if (dl.wr && dl.index == IDX_GAME) begin
				game_m = dl.data;
			end
			if (dl.wr && dl.index == IDX_DIP && dl.addr < 24'd8) begin
				dip_m[dl.addr[2:0]] = dl.data;
			end
			if (ps2_key[10] != last_tog) begin
				apply_key(ps2_key[7:0], ps2_key[9]);
				last_tog = ps2_key[10];
			end
			// One extra reset cycle RESET_HOLD clocks after the download ends
			cr_exp = status_reset | dlrom | !loaded | (loaded && n_after == RESET_HOLD);
			if (dl_prev && !dlrom) begin
				loaded  = 1'b1;
				n_after = 1;
			end else if (n_after != 0) begin
				n_after++;
			end
			dl_prev = dlrom;
		end
	end

	// ==============================
	// Comparison and reporting
	// ==============================

	task automatic report_mismatch(input string what, input logic [41:0] exp_v,
		input logic [41:0] act_v);
		$display("CHECK FAILED %s %s: expected %h, actual %h", test_names[test_id], what,
			exp_v, act_v);
		test_errors++;
		error_count++;
	endtask

	always @(negedge clk_sys) begin
		logic [41:0] exp_v;
		logic        led_exp;
		led_exp = dl.download && dl.index == IDX_ROM;
		if (started) begin
			test_checks += 2;
			if (core_reset !== cr_exp) begin
				report_mismatch("core_reset", 42'(cr_exp), 42'(core_reset));
			end
			if (led_user !== led_exp) begin
				report_mismatch("led_user", 42'(led_exp), 42'(led_user));
			end
		end
		if (check_now) begin
			exp_v = reference_ports();
			test_checks++;
			if ({ports, orientation} !== exp_v) begin
				report_mismatch("ports", exp_v, {ports, orientation});
			end
		end
		if (test_done) begin
			if (test_errors == 0) begin
				$display("PASS %s (%0d checks)", test_names[test_id], test_checks);
				tests_passed++;
			end else begin
				$display("FAIL %s (%0d of %0d checks wrong)", test_names[test_id],
					test_errors, test_checks);
				tests_failed++;
			end
			test_checks = 0;
			test_errors = 0;
		end
		if (all_done) begin
			$display("Summary: %0d tests passed, %0d failed, %0d check errors",
				tests_passed, tests_failed, error_count);
		end
	end

endmodule

// ==== tests/tb_top.sv ====
// Top-level testbench: drives the arcade input subsystem and reports the overall result
`timescale 1ns/1ps

module tb_top import arcade_input_pkg::*;;

	localparam int RESET_HOLD = 16;

	localparam logic [7:0] KEY_CODES [27] = '{8'h75, 8'h72, 8'h6B, 8'h74, 8'h14, 8'h11,
		8'h29, 8'h12, 8'h2D, 8'h2B, 8'h23, 8'h34, 8'h1C, 8'h1B, 8'h21, 8'h1D, 8'h05,
		8'h16, 8'h06, 8'h1E, 8'h76, 8'h2E, 8'h36, 8'h00, 8'h5A, 8'hF0, 8'h66};

	logic         clk_sys;
	logic         rst;
	dl_write_t    dl;
	logic         status_reset;
	logic [10:0]  ps2_key;
	logic [31:0]  joy1;
	logic [31:0]  joy2;
	logic         vsync;
	input_ports_t ports;
	logic [1:0]   orientation;
	logic         core_reset;
	logic         led_user;
	logic         check_now;
	int           test_id;
	logic         test_done;
	logic         all_done;
	int           error_count;
	int           tb_errors = 0;
	logic [31:0]  lfsr = 32'hcd9a;

	arcade_input_top #(.RESET_HOLD(RESET_HOLD)) dut (.clk_sys, .rst, .dl, .status_reset,
		.ps2_key, .joy1, .joy2, .vsync, .ports, .orientation, .core_reset, .led_user);

	input_checker #(.RESET_HOLD(RESET_HOLD)) u_checker (.clk_sys, .rst, .dl, .status_reset,
		.ps2_key, .joy1, .joy2, .vsync, .ports, .orientation, .core_reset, .led_user,
		.check_now, .test_id, .test_done, .all_done, .error_count);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int width);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < width; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hB4BCD35C) : (lfsr >> 1);
		end
		return v;
	endfunction

	task automatic check_ports();
		@(posedge clk_sys);
		@(posedge clk_sys);
		check_now <= 1'b1;
		@(posedge clk_sys);
		check_now <= 1'b0;
	endtask

	task automatic dl_write(input logic [7:0] index, input logic [23:0] addr,
		input logic [7:0] data);
		@(posedge clk_sys);
		dl <= '{download: 1'b0, wr: 1'b1, index: index, addr: addr, data: data};
		@(posedge clk_sys);
		dl <= '0;
		check_ports();
	endtask

	task automatic send_key(input logic [7:0] code, input logic pressed);
		@(posedge clk_sys);
		ps2_key <= {~ps2_key[10], pressed, 1'b0, code};
		check_ports();
	endtask

	task automatic set_joys(input logic [31:0] a, input logic [31:0] b);
		@(posedge clk_sys);
		joy1 <= a;
		joy2 <= b;
		check_ports();
	endtask

	task automatic pulse_vsync(input int count);
		repeat (count) begin
			@(posedge clk_sys);
			vsync <= 1'b1;
			@(posedge clk_sys);
			vsync <= 1'b0;
			repeat (2) @(posedge clk_sys);
		end
	endtask

	task automatic wait_core_reset(input logic level, input int limit);
		int cycles;
		cycles = 0;
		@(negedge clk_sys);
		while (core_reset !== level && cycles < limit) begin
			@(negedge clk_sys);
			cycles++;
		end
		if (core_reset !== level) begin
			$display("Timeout: core_reset did not reach %0b within %0d cycles", level, limit);
			tb_errors++;
		end
	endtask

	task automatic end_test();
		@(posedge clk_sys);
		test_done <= 1'b1;
		@(posedge clk_sys);
		test_done <= 1'b0;
		test_id   <= test_id + 1;
	endtask

	initial begin
		int idx;
		rst          = 1'b1;
		dl           = '0;
		status_reset = 1'b0;
		ps2_key      = '0;
		joy1         = '0;
		joy2         = '0;
		vsync        = 1'b0;
		check_now    = 1'b0;
		test_id      = 0;
		test_done    = 1'b0;
		all_done     = 1'b0;
		repeat (2) @(posedge clk_sys);
		rst <= 1'b0;

		// ROM download and the reset sequence after it
		repeat (3) @(posedge clk_sys);
		dl <= '{download: 1'b1, wr: 1'b0, index: IDX_ROM, addr: 24'd0, data: 8'd0};
		repeat (20) @(posedge clk_sys);
		dl <= '0;
		wait_core_reset(1'b0, 10);
		wait_core_reset(1'b1, RESET_HOLD + 5);
		wait_core_reset(1'b0, 5);
		end_test();

		// DIP bank, service bit and game select
		for (int i = 0; i < 8; i++) begin
			dl_write(IDX_DIP, 24'(i), 8'(rand_bits(8)) | 8'h01);
		end
		dl_write(IDX_DIP, 24'd8, 8'h5A);
		for (int g = 0; g < 6; g++) begin
			dl_write(IDX_GAME, 24'd0, 8'(g));
		end
		end_test();

		// Random joysticks on every game, then the Krooz'r stick extremes
		for (int g = 0; g < 6; g++) begin
			dl_write(IDX_GAME, 24'd0, 8'(g));
			repeat (8) set_joys(rand_bits(32), rand_bits(32));
		end
		dl_write(IDX_GAME, 24'd0, KROOZR);
		set_joys(32'h2, 32'h0);
		set_joys(32'h1, 32'h0);
		set_joys(32'h0, 32'h8);
		set_joys(32'h0, 32'h4);
		set_joys(32'h0, 32'h0);
		end_test();

		// Keyboard events, a few unknown codes mixed in
		for (int g = 0; g < 6; g++) begin
			dl_write(IDX_GAME, 24'd0, 8'(g));
			repeat (10) begin
				idx = int'(rand_bits(5));
				send_key((idx < 27) ? KEY_CODES[idx] : 8'(rand_bits(8)), rand_bits(1) != 0);
			end
		end
		for (int k = 0; k < 27; k++) begin
			send_key(KEY_CODES[k], 1'b0);
		end
		end_test();

		// Spinners across counted vsync rises
		for (int g = 1; g < 5; g++) begin
			dl_write(IDX_GAME, 24'd0, 8'(g));
			repeat (6) begin
				set_joys(rand_bits(32) & 32'hC000030F, rand_bits(32) & 32'hC000030F);
				pulse_vsync(1 + int'(rand_bits(2)));
				check_ports();
			end
			set_joys(32'h300, 32'h3);
			pulse_vsync(3);
			check_ports();
		end
		end_test();

		@(posedge clk_sys);
		all_done <= 1'b1;
		@(posedge clk_sys);
		all_done <= 1'b0;
		@(posedge clk_sys);
		if (error_count == 0 && tb_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== all.f ====
design/arcade_input_pkg.sv
design/download_regs.sv
design/ps2_key_decoder.sv
design/spinner.sv
design/input_port_mux.sv
design/arcade_input_top.sv
tests/arcade_input_asserts.sv
tests/input_checker.sv
tests/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the Verilator simulation of tb_top and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f all.f --top-module tb_top -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
echo "Simulation finished without failures"
